/* verilog/scpad_pkg.sv */
`default_nettype none

package scpad_pkg;

    ////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////

    parameter int NUM_SCPADS = 2;
    parameter int NUM_COLS   = 4;
    parameter int ROWS       = 64;
    parameter int ROW_W      = $clog2(ROWS);
    parameter int DATA_W     = 16;
    parameter int ID_W       = 4;
    // Keep at least one bit even for a single scratchpad
    parameter int SCPAD_W    = (NUM_SCPADS > 1) ? $clog2(NUM_SCPADS) : 1;

    ////////////////////////////////////////////////
    // Request, response and tag types
    ////////////////////////////////////////////////

    typedef logic [NUM_COLS-1:0] col_mask_t;

    // Column 0 sits in the low DATA_W bits
    typedef logic [NUM_COLS-1:0][DATA_W-1:0] line_t;

    typedef struct packed {
        logic [SCPAD_W-1:0] scpad_id;
        logic [ROW_W-1:0]   row;
        col_mask_t          enable_mask;
        logic [ID_W-1:0]    int_id;
    } sram_r_req_t;

    typedef struct packed {
        logic [SCPAD_W-1:0] scpad_id;
        logic [ROW_W-1:0]   row;
        col_mask_t          enable_mask;
        logic [ID_W-1:0]    int_id;
        line_t              wdata;
    } sram_w_req_t;

    typedef struct packed {
        logic [ID_W-1:0] int_id;
        line_t           rdata;
    } sram_r_res_t;

    typedef struct packed {
        logic [ID_W-1:0] int_id;
    } sram_w_res_t;

    // One outstanding access per scratchpad and direction
    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] int_id;
        col_mask_t       mask;
    } inflight_tag_t;

endpackage

`default_nettype wire

/* verilog/pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic n_rst,
    input  wire logic in_valid,
    output logic      in_ready,
    input  wire T     in_data,
    output logic      out_valid,
    input  wire logic out_ready,
    output T          out_data
);

    logic full;
    logic live;
    T     data_q;

    // Readiness starts one cycle after reset is released
    assign in_ready  = live && (!full || out_ready);
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            live <= 1'b0;
            full <= 1'b0;
        end else begin
            live <= 1'b1;
            if (in_ready) begin
                full <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/scpad_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_arbiter (
    input  wire logic                    clk,
    input  wire logic                    n_rst,
    input  wire logic                    rd_req_valid,
    output logic                         rd_req_ready,
    input  wire scpad_pkg::sram_r_req_t  rd_req,
    input  wire logic                    wr_req_valid,
    output logic                         wr_req_ready,
    input  wire scpad_pkg::sram_w_req_t  wr_req,
    output logic                         iss_rd_valid,
    input  wire logic                    iss_rd_ready,
    output scpad_pkg::sram_r_req_t       iss_rd,
    output logic                         iss_wr_valid,
    input  wire logic                    iss_wr_ready,
    output scpad_pkg::sram_w_req_t       iss_wr
);
    import scpad_pkg::*;

    logic wr_held_valid;
    logic wr_drain;
    logic conflict;

    pipe_reg #(.T(sram_r_req_t)) u_rd_slice (
        .clk       (clk),
        .n_rst     (n_rst),
        .in_valid  (rd_req_valid),
        .in_ready  (rd_req_ready),
        .in_data   (rd_req),
        .out_valid (iss_rd_valid),
        .out_ready (iss_rd_ready),
        .out_data  (iss_rd)
    );

    pipe_reg #(.T(sram_w_req_t)) u_wr_slice (
        .clk       (clk),
        .n_rst     (n_rst),
        .in_valid  (wr_req_valid),
        .in_ready  (wr_req_ready),
        .in_data   (wr_req),
        .out_valid (wr_held_valid),
        .out_ready (wr_drain),
        .out_data  (iss_wr)
    );

    ////////////////////////////////////////////////
    // Read before write on a bank conflict
    ////////////////////////////////////////////////

    // Same scratchpad and row with at least one shared column
    assign conflict = iss_rd_valid && wr_held_valid
                   && (iss_rd.scpad_id == iss_wr.scpad_id)
                   && (iss_rd.row == iss_wr.row)
                   && |(iss_rd.enable_mask & iss_wr.enable_mask);

    // Write stays parked until the read has left the slice
    assign iss_wr_valid = wr_held_valid && !conflict;
    assign wr_drain     = iss_wr_ready && !conflict;

endmodule

`default_nettype wire

/* verilog/scpad_bank_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_bank_ctrl (
    input  wire logic                                            clk,
    input  wire logic                                            n_rst,
    input  wire logic                                            iss_rd_valid,
    output logic                                                 iss_rd_ready,
    input  wire scpad_pkg::sram_r_req_t                          iss_rd,
    input  wire logic                                            iss_wr_valid,
    output logic                                                 iss_wr_ready,
    input  wire scpad_pkg::sram_w_req_t                          iss_wr,
    output scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]     ren,
    output scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]     wen,
    output logic [scpad_pkg::NUM_SCPADS-1:0][scpad_pkg::ROW_W-1:0] raddr,
    output logic [scpad_pkg::NUM_SCPADS-1:0][scpad_pkg::ROW_W-1:0] waddr,
    output scpad_pkg::line_t [scpad_pkg::NUM_SCPADS-1:0]         wdata,
    input  wire scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0] rdone,
    input  wire scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0] wdone,
    input  wire scpad_pkg::line_t [scpad_pkg::NUM_SCPADS-1:0]    rdata,
    output logic                                                 rd_res_valid,
    input  wire logic                                            rd_res_ready,
    output scpad_pkg::sram_r_res_t                               rd_res,
    output logic                                                 wr_res_valid,
    input  wire logic                                            wr_res_ready,
    output scpad_pkg::sram_w_res_t                               wr_res
);
    import scpad_pkg::*;

    inflight_tag_t [NUM_SCPADS-1:0] r_tag, w_tag;
    logic [NUM_SCPADS-1:0]          r_cmp, w_cmp, r_done, w_done, r_cand, w_cand;
    line_t [NUM_SCPADS-1:0]         r_buf;
    logic                           rd_fire, wr_fire, r_pick_ok, w_pick_ok, r_load, w_load;
    logic [SCPAD_W-1:0]             r_pick, w_pick, r_res_idx, w_res_idx;
    line_t                          r_pick_data;

    function automatic line_t mask_line(input line_t d, input col_mask_t m);
        line_t res;
        for (int c = 0; c < NUM_COLS; c++) begin
            res[c] = m[c] ? d[c] : '0;
        end
        return res;
    endfunction

    ////////////////////////////////////////////////
    // Issue into free slots
    ////////////////////////////////////////////////

    assign iss_rd_ready = !r_tag[iss_rd.scpad_id].valid;
    assign iss_wr_ready = !w_tag[iss_wr.scpad_id].valid;
    assign rd_fire      = iss_rd_valid && iss_rd_ready;
    assign wr_fire      = iss_wr_valid && iss_wr_ready;

    always_comb begin
        for (int s = 0; s < NUM_SCPADS; s++) begin
            ren[s]   = (rd_fire && iss_rd.scpad_id == SCPAD_W'(s)) ? iss_rd.enable_mask : '0;
            wen[s]   = (wr_fire && iss_wr.scpad_id == SCPAD_W'(s)) ? iss_wr.enable_mask : '0;
            raddr[s] = iss_rd.row;
            waddr[s] = iss_wr.row;
            wdata[s] = iss_wr.wdata;
            r_done[s] = r_tag[s].valid && |(rdone[s] & r_tag[s].mask);
            w_done[s] = w_tag[s].valid && |(wdone[s] & w_tag[s].mask);
            // The slot already held in the response register is not offered again
            r_cand[s] = (r_cmp[s] || r_done[s]) && !(rd_res_valid && r_res_idx == SCPAD_W'(s));
            w_cand[s] = (w_cmp[s] || w_done[s]) && !(wr_res_valid && w_res_idx == SCPAD_W'(s));
        end
    end

    // Lowest scratchpad index wins
    always_comb begin
        r_pick_ok = 1'b0;
        w_pick_ok = 1'b0;
        r_pick    = '0;
        w_pick    = '0;
        for (int s = NUM_SCPADS - 1; s >= 0; s--) begin
            if (r_cand[s]) begin
                r_pick_ok = 1'b1;
                r_pick    = SCPAD_W'(s);
            end
            if (w_cand[s]) begin
                w_pick_ok = 1'b1;
                w_pick    = SCPAD_W'(s);
            end
        end
    end

    // A completion arriving this cycle bypasses its buffer
    assign r_pick_data = r_cmp[r_pick] ? r_buf[r_pick]
                                       : mask_line(rdata[r_pick], r_tag[r_pick].mask);
    assign r_load = r_pick_ok && (!rd_res_valid || rd_res_ready);
    assign w_load = w_pick_ok && (!wr_res_valid || wr_res_ready);

    ////////////////////////////////////////////////
    // Slot state and response registers
    ////////////////////////////////////////////////

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            r_tag        <= '0;
            w_tag        <= '0;
            r_cmp        <= '0;
            w_cmp        <= '0;
            rd_res_valid <= 1'b0;
            wr_res_valid <= 1'b0;
        end else begin
            for (int s = 0; s < NUM_SCPADS; s++) begin
                if (rd_fire && iss_rd.scpad_id == SCPAD_W'(s)) begin
                    r_tag[s] <= '{valid: 1'b1, int_id: iss_rd.int_id, mask: iss_rd.enable_mask};
                end else if (rd_res_valid && rd_res_ready && r_res_idx == SCPAD_W'(s)) begin
                    r_tag[s].valid <= 1'b0;
                    r_cmp[s]       <= 1'b0;
                end else if (r_done[s]) begin
                    r_cmp[s] <= 1'b1;
                end
                if (wr_fire && iss_wr.scpad_id == SCPAD_W'(s)) begin
                    w_tag[s] <= '{valid: 1'b1, int_id: iss_wr.int_id, mask: iss_wr.enable_mask};
                end else if (wr_res_valid && wr_res_ready && w_res_idx == SCPAD_W'(s)) begin
                    w_tag[s].valid <= 1'b0;
                    w_cmp[s]       <= 1'b0;
                end else if (w_done[s]) begin
                    w_cmp[s] <= 1'b1;
                end
            end
            if (r_load) begin
                rd_res_valid <= 1'b1;
            end else if (rd_res_ready) begin
                rd_res_valid <= 1'b0;
            end
            if (w_load) begin
                wr_res_valid <= 1'b1;
            end else if (wr_res_ready) begin
                wr_res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SCPADS; s++) begin
            if (r_done[s]) begin
                r_buf[s] <= mask_line(rdata[s], r_tag[s].mask);
            end
        end
        if (r_load) begin
            rd_res    <= '{int_id: r_tag[r_pick].int_id, rdata: r_pick_data};
            r_res_idx <= r_pick;
        end
        if (w_load) begin
            wr_res.int_id <= w_tag[w_pick].int_id;
            w_res_idx     <= w_pick;
        end
    end

endmodule

`default_nettype wire

/* verilog/scpad_bank_array.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_bank_array #(
    parameter int BANK_LAT = 2
) (
    input  wire logic                                              clk,
    input  wire logic                                              n_rst,
    input  wire scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]  ren,
    input  wire scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]  wen,
    input  wire logic [scpad_pkg::NUM_SCPADS-1:0][scpad_pkg::ROW_W-1:0] raddr,
    input  wire logic [scpad_pkg::NUM_SCPADS-1:0][scpad_pkg::ROW_W-1:0] waddr,
    input  wire scpad_pkg::line_t [scpad_pkg::NUM_SCPADS-1:0]      wdata,
    output scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]       rdone,
    output scpad_pkg::line_t [scpad_pkg::NUM_SCPADS-1:0]           rdata,
    output scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]       wdone
);
    import scpad_pkg::*;

    // One bank per scratchpad and column
    logic [DATA_W-1:0] mem [NUM_SCPADS][NUM_COLS][ROWS];

    col_mask_t [BANK_LAT-1:0][NUM_SCPADS-1:0] r_pipe, w_pipe;
    line_t [BANK_LAT-1:0][NUM_SCPADS-1:0]     d_pipe;

    assign rdone = r_pipe[BANK_LAT-1];
    assign wdone = w_pipe[BANK_LAT-1];
    assign rdata = d_pipe[BANK_LAT-1];

    ////////////////////////////////////////////////
    // Done pulses delayed by BANK_LAT
    ////////////////////////////////////////////////

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            r_pipe <= '0;
            w_pipe <= '0;
        end else begin
            r_pipe[0] <= ren;
            w_pipe[0] <= wen;
            for (int i = 1; i < BANK_LAT; i++) begin
                r_pipe[i] <= r_pipe[i-1];
                w_pipe[i] <= w_pipe[i-1];
            end
        end
    end

    // Read samples the old contents when a write hits the same row
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SCPADS; s++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (wen[s][c]) begin
                    mem[s][c][waddr[s]] <= wdata[s][c];
                end
                d_pipe[0][s][c] <= ren[s][c] ? mem[s][c][raddr[s]] : '0;
            end
        end
        for (int i = 1; i < BANK_LAT; i++) begin
            d_pipe[i] <= d_pipe[i-1];
        end
    end

endmodule

`default_nettype wire

/* verilog/scpad_top.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_top #(
    parameter int BANK_LAT = 2
) (
    input  wire logic                    clk,
    input  wire logic                    n_rst,
    input  wire logic                    rd_req_valid,
    output logic                         rd_req_ready,
    input  wire scpad_pkg::sram_r_req_t  rd_req,
    input  wire logic                    wr_req_valid,
    output logic                         wr_req_ready,
    input  wire scpad_pkg::sram_w_req_t  wr_req,
    output logic                         rd_res_valid,
    input  wire logic                    rd_res_ready,
    output scpad_pkg::sram_r_res_t       rd_res,
    output logic                         wr_res_valid,
    input  wire logic                    wr_res_ready,
    output scpad_pkg::sram_w_res_t       wr_res
);
    import scpad_pkg::*;

    // Arbiter to bank controller
    logic        iss_rd_valid, iss_rd_ready, iss_wr_valid, iss_wr_ready;
    sram_r_req_t iss_rd;
    sram_w_req_t iss_wr;

    // Bank controller to bank array
    col_mask_t [NUM_SCPADS-1:0]        ren, wen, rdone, wdone;
    logic [NUM_SCPADS-1:0][ROW_W-1:0]  raddr, waddr;
    line_t [NUM_SCPADS-1:0]            wdata, rdata;

    scpad_arbiter u_arbiter (
        .clk (clk), .n_rst (n_rst),
        .rd_req_valid (rd_req_valid), .rd_req_ready (rd_req_ready), .rd_req (rd_req),
        .wr_req_valid (wr_req_valid), .wr_req_ready (wr_req_ready), .wr_req (wr_req),
        .iss_rd_valid (iss_rd_valid), .iss_rd_ready (iss_rd_ready), .iss_rd (iss_rd),
        .iss_wr_valid (iss_wr_valid), .iss_wr_ready (iss_wr_ready), .iss_wr (iss_wr)
    );

    scpad_bank_ctrl u_bank_ctrl (
        .clk (clk), .n_rst (n_rst),
        .iss_rd_valid (iss_rd_valid), .iss_rd_ready (iss_rd_ready), .iss_rd (iss_rd),
        .iss_wr_valid (iss_wr_valid), .iss_wr_ready (iss_wr_ready), .iss_wr (iss_wr),
        .ren (ren), .wen (wen), .raddr (raddr), .waddr (waddr), .wdata (wdata),
        .rdone (rdone), .wdone (wdone), .rdata (rdata),
        .rd_res_valid (rd_res_valid), .rd_res_ready (rd_res_ready), .rd_res (rd_res),
        .wr_res_valid (wr_res_valid), .wr_res_ready (wr_res_ready), .wr_res (wr_res)
    );

    scpad_bank_array #(.BANK_LAT(BANK_LAT)) u_bank_array (
        .clk (clk), .n_rst (n_rst),
        .ren (ren), .wen (wen), .raddr (raddr), .waddr (waddr), .wdata (wdata),
        .rdone (rdone), .rdata (rdata), .wdone (wdone)
    );

endmodule

`default_nettype wire

/* bench/scpad_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_checker (
    input wire logic                                                  clk,
    input wire logic                                                  n_rst,
    input wire scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]      ren,
    input wire scpad_pkg::col_mask_t [scpad_pkg::NUM_SCPADS-1:0]      wen,
    input wire scpad_pkg::sram_r_req_t                                iss_rd,
    input wire scpad_pkg::sram_w_req_t                                iss_wr,
    input wire logic                                                  rd_res_valid,
    input wire logic                                                  rd_res_ready,
    input wire scpad_pkg::sram_r_res_t                                rd_res,
    input wire logic                                                  wr_res_valid,
    input wire logic                                                  wr_res_ready,
    input wire scpad_pkg::sram_w_res_t                                wr_res
);
    import scpad_pkg::*;

    // Slot occupancy rebuilt from the strobes and the accepted responses
    inflight_tag_t [NUM_SCPADS-1:0] r_shadow, w_shadow;
    logic                           busy_issue;
    int                             fail_count = 0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            r_shadow <= '0;
            w_shadow <= '0;
        end else begin
            for (int s = 0; s < NUM_SCPADS; s++) begin
                if (|ren[s]) begin
                    r_shadow[s] <= '{valid: 1'b1, int_id: iss_rd.int_id, mask: ren[s]};
                end else if (rd_res_valid && rd_res_ready
                             && rd_res.int_id == r_shadow[s].int_id) begin
                    r_shadow[s].valid <= 1'b0;
                end
                if (|wen[s]) begin
                    w_shadow[s] <= '{valid: 1'b1, int_id: iss_wr.int_id, mask: wen[s]};
                end else if (wr_res_valid && wr_res_ready
                             && wr_res.int_id == w_shadow[s].int_id) begin
                    w_shadow[s].valid <= 1'b0;
                end
            end
        end
    end

    // A strobe into a scratchpad whose slot still holds an access
    always_comb begin
        busy_issue = 1'b0;
        for (int s = 0; s < NUM_SCPADS; s++) begin
            if ((|ren[s] && r_shadow[s].valid) || (|wen[s] && w_shadow[s].valid)) begin
                busy_issue = 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!n_rst)
        rd_res_valid && !rd_res_ready |=> rd_res_valid && $stable(rd_res))
        else begin
            fail_count++;
            $error("read response changed while stalled");
        end

    assert property (@(posedge clk) disable iff (!n_rst)
        wr_res_valid && !wr_res_ready |=> wr_res_valid && $stable(wr_res))
        else begin
            fail_count++;
            $error("write response changed while stalled");
        end

    assert property (@(posedge clk) disable iff (!n_rst) !busy_issue)
        else begin
            fail_count++;
            $error("bank access issued into a busy slot");
        end

    assert property (@(posedge clk) $rose(n_rst) |-> (ren == '0 && wen == '0))
        else begin
            fail_count++;
            $error("bank strobes active right after reset release");
        end

endmodule

bind scpad_bank_ctrl scpad_checker u_checker (.*);

`default_nettype wire

/* bench/scpad_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_tb;
    import scpad_pkg::*;

    localparam int TIMEOUT = 2000;
    localparam int NUM_IDS = 2**ID_W;

    logic        clk = 1'b0;
    logic        n_rst;
    logic        rd_req_valid, rd_req_ready, wr_req_valid, wr_req_ready;
    logic        rd_res_valid, rd_res_ready, wr_res_valid, wr_res_ready;
    sram_r_req_t rd_req;
    sram_w_req_t wr_req;
    sram_r_res_t rd_res;
    sram_w_res_t wr_res;

    integer seed = 32'h8059f46c;
    int     errors = 0;
    int     timeouts = 0;
    string  test_name = "reset";
    bit     bp_en = 1'b0;

    // Reference memory and outstanding requests keyed by int_id
    line_t              model [NUM_SCPADS][ROWS];
    line_t              exp_rd [NUM_IDS];
    sram_r_req_t        rd_pend [NUM_IDS];
    sram_w_req_t        wr_pend [NUM_IDS];
    logic [NUM_IDS-1:0] rd_busy = '0;
    logic [NUM_IDS-1:0] wr_busy = '0;
    int                 pend_rd [NUM_SCPADS][ROWS];
    int                 pend_wr [NUM_SCPADS][ROWS];
    // Handshakes due on the coming rising edge
    logic               rd_take = 1'b0;
    logic               wr_take = 1'b0;
    sram_r_req_t        done_rd;
    sram_w_req_t        done_wr;

    always #20 clk = ~clk;

    scpad_top #(.BANK_LAT(2)) UUT (
        .clk          (clk),
        .n_rst        (n_rst),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .rd_req       (rd_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .wr_req       (wr_req),
        .rd_res_valid (rd_res_valid),
        .rd_res_ready (rd_res_ready),
        .rd_res       (rd_res),
        .wr_res_valid (wr_res_valid),
        .wr_res_ready (wr_res_ready),
        .wr_res       (wr_res)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic line_t expected_read(input int s, input int row, input col_mask_t m);
        line_t l;
        for (int c = 0; c < NUM_COLS; c++) begin
            l[c] = m[c] ? model[s][row][c] : '0;
        end
        return l;
    endfunction

    // Distinct word for every scratchpad, row and column
    function automatic line_t fill_line(input int s, input int row);
        line_t l;
        for (int c = 0; c < NUM_COLS; c++) begin
            l[c] = 16'ha000 ^ DATA_W'(s << 12) ^ DATA_W'(row << 4) ^ DATA_W'(c);
        end
        return l;
    endfunction

    function automatic int free_id(input logic [NUM_IDS-1:0] busy);
        for (int i = 0; i < NUM_IDS; i++) begin
            if (!busy[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Comparison runs at the falling edge where every output has settled
    always @(negedge clk) begin
        rd_take = rd_req_valid && rd_req_ready;
        wr_take = wr_req_valid && wr_req_ready;
        if (rd_res_valid && rd_res_ready) begin
            if (!rd_busy[rd_res.int_id]) begin
                $display("%s: read response for int_id %0d that is not outstanding",
                         test_name, rd_res.int_id);
                errors++;
            end else begin
                if (rd_res.rdata !== exp_rd[rd_res.int_id]) begin
                    $display("CHECK FAILED %s read id %0d expected %h actual %h", test_name,
                             rd_res.int_id, exp_rd[rd_res.int_id], rd_res.rdata);
                    errors++;
                end
                done_rd = rd_pend[rd_res.int_id];
                pend_rd[done_rd.scpad_id][done_rd.row]--;
                rd_busy[rd_res.int_id] = 1'b0;
            end
        end
        if (wr_res_valid && wr_res_ready) begin
            if (!wr_busy[wr_res.int_id]) begin
                $display("%s: write response for int_id %0d that is not outstanding",
                         test_name, wr_res.int_id);
                errors++;
            end else begin
                done_wr = wr_pend[wr_res.int_id];
                for (int c = 0; c < NUM_COLS; c++) begin
                    if (done_wr.enable_mask[c]) begin
                        model[done_wr.scpad_id][done_wr.row][c] = done_wr.wdata[c];
                    end
                end
                pend_wr[done_wr.scpad_id][done_wr.row]--;
                wr_busy[wr_res.int_id] = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic present_rd(input int s, input int row, input col_mask_t m, input int id);
        rd_req = '{scpad_id: SCPAD_W'(s), row: ROW_W'(row), enable_mask: m,
                   int_id: ID_W'(id)};
        exp_rd[id] = expected_read(s, row, m);
        rd_pend[id] = rd_req;
        rd_busy[id] = 1'b1;
        pend_rd[s][row]++;
        rd_req_valid = 1'b1;
    endtask

    task automatic present_wr(input int s, input int row, input col_mask_t m, input int id,
                              input line_t d);
        wr_req = '{scpad_id: SCPAD_W'(s), row: ROW_W'(row), enable_mask: m,
                   int_id: ID_W'(id), wdata: d};
        wr_pend[id] = wr_req;
        wr_busy[id] = 1'b1;
        pend_wr[s][row]++;
        wr_req_valid = 1'b1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        while ((rd_req_valid || wr_req_valid) && n < TIMEOUT) begin
            tick();
            if (rd_take) rd_req_valid = 1'b0;
            if (wr_take) wr_req_valid = 1'b0;
            n++;
        end
        if (rd_req_valid || wr_req_valid) begin
            $display("%s: timeout waiting for a request to be accepted", test_name);
            timeouts++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((rd_busy != '0 || wr_busy != '0) && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (rd_busy != '0 || wr_busy != '0) begin
            $display("%s: timeout waiting for outstanding responses", test_name);
            timeouts++;
        end
    endtask

    task automatic do_rd(input int s, input int row, input col_mask_t m);
        int id;
        id = free_id(rd_busy);
        if (id < 0) drain();
        present_rd(s, row, m, free_id(rd_busy));
        wait_accept();
    endtask

    task automatic do_wr(input int s, input int row, input col_mask_t m, input line_t d);
        int id;
        id = free_id(wr_busy);
        if (id < 0) drain();
        present_wr(s, row, m, free_id(wr_busy), d);
        wait_accept();
    endtask

    // Random traffic on rows 0..7, never mixing a read and a write to one row
    task automatic random_stream(input int count);
        int        sent, n, s, row, id;
        col_mask_t m;
        sent = 0;
        n = 0;
        while ((sent < count || rd_req_valid || wr_req_valid) && n < 4 * TIMEOUT) begin
            tick();
            n++;
            if (rd_take) rd_req_valid = 1'b0;
            if (wr_take) wr_req_valid = 1'b0;
            if (bp_en) begin
                rd_res_ready = ($random(seed) & 3) != 0;
                wr_res_ready = ($random(seed) & 3) != 0;
            end
            s = {$random(seed)} % NUM_SCPADS;
            row = {$random(seed)} % 8;
            m = col_mask_t'($random(seed));
            id = free_id(rd_busy);
            if (sent < count && !rd_req_valid && id >= 0 && m != '0
                && pend_wr[s][row] == 0) begin
                present_rd(s, row, m, id);
                sent++;
            end
            s = {$random(seed)} % NUM_SCPADS;
            row = {$random(seed)} % 8;
            m = col_mask_t'($random(seed));
            id = free_id(wr_busy);
            if (sent < count && !wr_req_valid && id >= 0 && m != '0
                && pend_wr[s][row] == 0 && pend_rd[s][row] == 0) begin
                present_wr(s, row, m, id, {$random(seed), $random(seed)});
                sent++;
            end
        end
        if (sent < count || rd_req_valid || wr_req_valid) begin
            $display("%s: timeout in random stream after %0d requests", test_name, sent);
            timeouts++;
        end
        rd_res_ready = 1'b1;
        wr_res_ready = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int n;
        int idr;
        int idw;
        n_rst = 1'b0;
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        rd_req = '0;
        wr_req = '0;
        rd_res_ready = 1'b1;
        wr_res_ready = 1'b1;
        for (int s = 0; s < NUM_SCPADS; s++) begin
            for (int r = 0; r < ROWS; r++) begin
                model[s][r] = '0;
                pend_rd[s][r] = 0;
                pend_wr[s][r] = 0;
            end
        end

        repeat (10) begin
            tick();
            if ({rd_req_ready, wr_req_ready, rd_res_valid, wr_res_valid} !== 4'b0000) begin
                $display("CHECK FAILED %s ready/valid expected 0000 actual %b", test_name,
                         {rd_req_ready, wr_req_ready, rd_res_valid, wr_res_valid});
                errors++;
            end
        end
        n_rst = 1'b1;
        n = 0;
        while (!(rd_req_ready && wr_req_ready) && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!(rd_req_ready && wr_req_ready)) begin
            $display("%s: request readies never rose after reset", test_name);
            timeouts++;
        end

        test_name = "write_then_read";
        for (int s = 0; s < NUM_SCPADS; s++) begin
            for (int r = 0; r < 8; r++) begin
                do_wr(s, r, '1, fill_line(s, r));
            end
        end
        drain();
        for (int s = 0; s < NUM_SCPADS; s++) begin
            for (int r = 0; r < 8; r++) begin
                do_rd(s, r, '1);
            end
        end
        drain();

        test_name = "partial_mask";
        do_wr(1, 3, 4'b0101, {$random(seed), $random(seed)});
        do_wr(0, 6, 4'b1000, {$random(seed), $random(seed)});
        drain();
        do_rd(1, 3, '1);
        do_rd(1, 3, 4'b1010);
        do_rd(0, 6, 4'b0011);
        drain();

        // Read and overlapping write offered in the same cycle
        test_name = "same_cycle_conflict";
        // Parked read keeps slot 0 busy while the pair waits in the arbiter
        rd_res_ready = 1'b0;
        do_rd(0, 4, '1);
        idr = free_id(rd_busy);
        idw = free_id(wr_busy);
        present_rd(0, 5, '1, idr);
        present_wr(0, 5, 4'b0110, idw, {$random(seed), $random(seed)});
        wait_accept();
        n = 0;
        while (!rd_res_valid && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!rd_res_valid) begin
            $display("%s: timeout waiting for the parked read response", test_name);
            timeouts++;
        end
        rd_res_ready = 1'b1;
        drain();
        do_rd(0, 5, '1);
        drain();

        test_name = "interleaved";
        random_stream(60);
        drain();

        test_name = "back_pressure";
        bp_en = 1'b1;
        random_stream(80);
        bp_en = 1'b0;
        drain();

        $display("Errors: %0d, timeouts: %0d, assertion failures: %0d", errors, timeouts,
                 UUT.u_bank_ctrl.u_checker.fail_count);
        if (errors == 0 && timeouts == 0 && UUT.u_bank_ctrl.u_checker.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/scpad_pkg.sv
verilog/pipe_reg.sv
verilog/scpad_arbiter.sv
verilog/scpad_bank_ctrl.sv
verilog/scpad_bank_array.sv
verilog/scpad_top.sv
bench/scpad_checker.sv
bench/scpad_tb.sv

/* Bender.yml */
package:
  name: scpad

sources:
  # Shared types first, then the RTL from leaf to top
  - verilog/scpad_pkg.sv
  - verilog/pipe_reg.sv
  - verilog/scpad_arbiter.sv
  - verilog/scpad_bank_ctrl.sv
  - verilog/scpad_bank_array.sv
  - verilog/scpad_top.sv

  - target: simulation
    files:
      - bench/scpad_checker.sv
      - bench/scpad_tb.sv
